// ==== src/bnn_pkg.sv ====
package bnn_pkg;

    //////////////////////////////
    // stream interface
    //////////////////////////////

    // fixed by the downstream consumer
    localparam int unsigned STREAM_W = 64;

    //////////////////////////////
    // ping-pong bank select
    //////////////////////////////

    // names the bank that is accumulating now
    // the other one holds the last finished frame
    typedef enum logic {
        BANK_0 = 1'b0,
        BANK_1 = 1'b1
    } bank_sel_e;

    //////////////////////////////
    // control and data structs
    //////////////////////////////

    // sequencer to destination buffer
    typedef struct packed {
        // product beat present on result
        logic      acc_v;
        // last beat of the frame
        logic      s_fin;
        // bank that takes this beat
        bank_sel_e bank;
    } acc_ctrl_t;

    // one output word, valid for a single cycle
    typedef struct packed {
        logic                valid;
        logic [STREAM_W-1:0] data;
    } stream_out_t;

endpackage

// ==== src/xnor_core.sv ====
`timescale 1ns/1ps

module xnor_core #(
    parameter int unsigned NEURONS = 32
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_v,
    input  logic               in_act,
    input  logic [NEURONS-1:0] in_w,
    output logic [NEURONS-1:0] result,
    output logic               res_v
);

    //////////////////////////////
    // binarized multiply
    //////////////////////////////

    // +1/-1 encoded as 1/0, so the product is an xnor
    // one activation bit fans out to every neuron
    logic [NEURONS-1:0] act_rep;
    logic [NEURONS-1:0] prod;

    // replicate the activation across the weight word
    assign act_rep = {NEURONS{in_act}};

    // bit i is one when act and weight i agree
    assign prod = ~(act_rep ^ in_w);

    //////////////////////////////
    // pipeline register
    //////////////////////////////

    // valid strobe, cleared by reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_v <= 1'b0;
        end else begin
            res_v <= in_v;
        end
    end

    // product payload, only loaded on a beat
    // holds its value between beats
    always_ff @(posedge clk) begin
        if (in_v) begin
            result <= prod;
        end
    end

endmodule

// ==== src/seq_ctrl.sv ====
`timescale 1ns/1ps

module seq_ctrl #(
    parameter int unsigned VEC_LEN = 64
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              res_v,
    output bnn_pkg::acc_ctrl_t ctrl
);

    import bnn_pkg::*;

    // enough bits for 0 .. VEC_LEN-1
    localparam int unsigned BEAT_W = $clog2(VEC_LEN);

    // index of the last beat in a frame
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(VEC_LEN - 1);

    //////////////////////////////
    // beat counter
    //////////////////////////////

    // number of product beats seen in the current frame
    logic [BEAT_W-1:0] beat_cnt;

    // bank currently accumulating
    bank_sel_e         bank;

    // last beat of the frame is on result now
    logic              last_beat;

    assign last_beat = res_v && (beat_cnt == LAST_BEAT);

    // count only product beats, gaps leave it alone
    // wrap at frame end so the next beat starts a new frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (res_v) begin
            if (last_beat) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // ping-pong select
    //////////////////////////////

    // flip on every frame end
    // next frame lands in the other bank with no idle cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bank <= BANK_0;
        end else if (last_beat) begin
            bank <= (bank == BANK_0) ? BANK_1 : BANK_0;
        end
    end

    //////////////////////////////
    // control word
    //////////////////////////////

    // purely combinational, adds no latency to result
    always_comb begin
        ctrl       = '0;
        ctrl.acc_v = res_v;
        ctrl.s_fin = last_beat;
        // bank seen by this beat, the flip takes effect after it
        ctrl.bank  = bank;
    end

endmodule

// ==== src/sign_counter.sv ====
`timescale 1ns/1ps

module sign_counter #(
    parameter int unsigned CNT_W = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic result_bit,
    input  logic acc_v,
    input  logic active,
    input  logic s_fin,
    output logic sign_bit
);

    // unit step of the accumulator
    localparam logic signed [CNT_W-1:0] STEP = CNT_W'(1);

    //////////////////////////////
    // plus/minus accumulator
    //////////////////////////////

    // signed popcount, wide enough for +-VEC_LEN
    // so no saturation logic needed
    logic signed [CNT_W-1:0] cnt;
    logic signed [CNT_W-1:0] cnt_nxt;

    // enabled only while this bank is selected
    logic                    en;

    assign en = acc_v && active;

    // count with the current beat folded in
    always_comb begin
        cnt_nxt = cnt;
        if (en) begin
            if (result_bit) begin
                cnt_nxt = cnt + STEP;
            end else begin
                cnt_nxt = cnt - STEP;
            end
        end
    end

    // clear on the last beat, the sign is taken from cnt_nxt
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (en) begin
            if (s_fin) begin
                cnt <= '0;
            end else begin
                cnt <= cnt_nxt;
            end
        end
    end

    // binarized activation, a tie counts as nonnegative
    assign sign_bit = ~cnt_nxt[CNT_W-1];

endmodule

// ==== src/dst_buf.sv ====
`timescale 1ns/1ps

module dst_buf #(
    parameter int unsigned NEURONS = 32,
    parameter int unsigned VEC_LEN = 64
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [NEURONS-1:0]  result,
    input  bnn_pkg::acc_ctrl_t  ctrl,
    input  logic                rd_req,
    output bnn_pkg::stream_out_t stream
);

    import bnn_pkg::*;

    // signed range -VEC_LEN .. +VEC_LEN plus a sign bit
    localparam int unsigned CNT_W = $clog2(VEC_LEN + 1) + 1;

    //////////////////////////////
    // bank enables
    //////////////////////////////

    logic act_0;
    logic act_1;

    assign act_0 = (ctrl.bank == BANK_0);
    assign act_1 = (ctrl.bank == BANK_1);

    // sign vectors, one per bank
    logic [NEURONS-1:0] sign_0;
    logic [NEURONS-1:0] sign_1;

    //////////////////////////////
    // bank 0 counters
    //////////////////////////////

    for (genvar i = 0; i < NEURONS; i++) begin : gen_bank0
        sign_counter #(
            .CNT_W (CNT_W)
        ) cnt_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .result_bit (result[i]),
            .acc_v      (ctrl.acc_v),
            .active     (act_0),
            .s_fin      (ctrl.s_fin),
            .sign_bit   (sign_0[i])
        );
    end

    //////////////////////////////
    // bank 1 counters
    //////////////////////////////

    for (genvar j = 0; j < NEURONS; j++) begin : gen_bank1
        sign_counter #(
            .CNT_W (CNT_W)
        ) cnt_i (
            .clk        (clk),
            .arst_n     (arst_n),
            .result_bit (result[j]),
            .acc_v      (ctrl.acc_v),
            .active     (act_1),
            .s_fin      (ctrl.s_fin),
            .sign_bit   (sign_1[j])
        );
    end

    //////////////////////////////
    // latched sign buffers
    //////////////////////////////

    // finished frame words, upper bits stay zero
    // reset to zero so an early read returns all zeros
    logic [STREAM_W-1:0] buf_0;
    logic [STREAM_W-1:0] buf_1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_0 <= '0;
            buf_1 <= '0;
        end else if (ctrl.s_fin) begin
            // only the bank that just finished is latched
            if (act_0) begin
                buf_0 <= STREAM_W'(sign_0);
            end else begin
                buf_1 <= STREAM_W'(sign_1);
            end
        end
    end

    //////////////////////////////
    // stream output register
    //////////////////////////////

    logic                out_v;
    logic [STREAM_W-1:0] out_d;

    // one-cycle valid per read strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_v <= 1'b0;
        end else begin
            out_v <= rd_req;
        end
    end

    // send the bank that is not accumulating
    // at the latch edge the select has not flipped yet,
    // so a read there still sees the previous frame
    always_ff @(posedge clk) begin
        if (rd_req) begin
            out_d <= act_0 ? buf_1 : buf_0;
        end
    end

    assign stream.valid = out_v;
    assign stream.data  = out_d;

endmodule

// ==== src/bnn_out_top.sv ====
`timescale 1ns/1ps

module bnn_out_top #(
    parameter int unsigned NEURONS = 32,
    parameter int unsigned VEC_LEN = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_v,
    input  logic                 in_act,
    input  logic                 rd_req,
    input  logic [NEURONS-1:0]   in_w,
    output bnn_pkg::stream_out_t stream
);

    import bnn_pkg::*;

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // registered products and their strobe
    logic [NEURONS-1:0] result;
    logic               res_v;

    // beat marking and bank select
    acc_ctrl_t          ctrl;

    //////////////////////////////
    // multiply stage
    //////////////////////////////

    xnor_core #(
        .NEURONS (NEURONS)
    ) xnor_i (
        .clk    (clk),
        .arst_n (arst_n),
        .in_v   (in_v),
        .in_act (in_act),
        .in_w   (in_w),
        .result (result),
        .res_v  (res_v)
    );

    //////////////////////////////
    // frame sequencer
    //////////////////////////////

    seq_ctrl #(
        .VEC_LEN (VEC_LEN)
    ) seq_i (
        .clk    (clk),
        .arst_n (arst_n),
        .res_v  (res_v),
        .ctrl   (ctrl)
    );

    //////////////////////////////
    // accumulate and output
    //////////////////////////////

    dst_buf #(
        .NEURONS (NEURONS),
        .VEC_LEN (VEC_LEN)
    ) dst_i (
        .clk    (clk),
        .arst_n (arst_n),
        .result (result),
        .ctrl   (ctrl),
        .rd_req (rd_req),
        .stream (stream)
    );

endmodule

// ==== tb/bnn_ref_model.svh ====
`ifndef BNN_REF_MODEL_SVH
`define BNN_REF_MODEL_SVH

//////////////////////////////
// frame reference model
//////////////////////////////

// per neuron, beats where act matched the weight bit
int unsigned         match_cnt [NEURONS];
int unsigned         beat_idx;

// finished frame words and the edge that sampled their last beat
logic [STREAM_W-1:0] frame_word [$];
int unsigned         frame_done [$];

function void model_reset();
    for (int i = 0; i < NEURONS; i++) begin
        match_cnt[i] = 0;
    end
    beat_idx = 0;
    frame_word.delete();
    frame_done.delete();
endfunction

// one beat as the DUT sees it, edge_idx is the sampling edge
function void record_beat(input logic act, input logic [NEURONS-1:0] w,
                          input int unsigned edge_idx);
    logic [STREAM_W-1:0] word;
    word = '0;
    for (int i = 0; i < NEURONS; i++) begin
        if (act == w[i]) begin
            match_cnt[i]++;
        end
    end
    beat_idx++;
    if (beat_idx == VEC_LEN) begin
        // sign is one when ones are at least half, tie included
        for (int i = 0; i < NEURONS; i++) begin
            word[i] = (2 * match_cnt[i] >= VEC_LEN);
            match_cnt[i] = 0;
        end
        frame_word.push_back(word);
        frame_done.push_back(edge_idx);
        beat_idx = 0;
    end
endfunction

// newest frame readable at this edge, two edges after its last beat
function logic [STREAM_W-1:0] expected_word(input int unsigned read_idx);
    for (int k = frame_word.size() - 1; k >= 0; k--) begin
        if (frame_done[k] + 2 <= read_idx) begin
            return frame_word[k];
        end
    end
    return '0;
endfunction

`endif

// ==== tb/tb_bnn_out.sv ====
`timescale 1ns/1ps

module tb_bnn_out;

    import bnn_pkg::*;

    localparam int unsigned NEURONS      = 32;
    localparam int unsigned VEC_LEN      = 64;
    localparam int unsigned CLK_PERIOD   = 100;
    localparam int unsigned MAX_GAP      = 3;
    localparam int unsigned N_B2B_FRAMES = 8;
    localparam int unsigned N_GAP_FRAMES = 6;
    // plus single, three directed and read-at-latch frames
    localparam int unsigned N_FRAMES     = N_B2B_FRAMES + N_GAP_FRAMES + 5;
    localparam int unsigned TIMEOUT_CYC  = N_FRAMES * VEC_LEN * (MAX_GAP + 1) + 500;

    // frame content modes
    localparam int MODE_RAND  = 0;
    localparam int MODE_ONES  = 1;
    localparam int MODE_ZEROS = 2;
    localparam int MODE_HALF  = 3;

    logic               clk;
    logic               arst_n;
    logic               in_v;
    logic               in_act;
    logic               rd_req;
    logic [NEURONS-1:0] in_w;
    stream_out_t        stream;

    // edge index that moves at the falling edge
    int unsigned        cyc;
    int unsigned        err_cnt;
    int unsigned        check_cnt;
    string              test_name;
    logic [31:0]        lcg_state;

    `include "bnn_ref_model.svh"

    bnn_out_top #(
        .NEURONS (NEURONS),
        .VEC_LEN (VEC_LEN)
    ) dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .in_v   (in_v),
        .in_act (in_act),
        .rd_req (rd_req),
        .in_w   (in_w),
        .stream (stream)
    );

    //////////////////////////////
    // clock, edge count, watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [STREAM_W-1:0] exp,
                               input logic [STREAM_W-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, exp, act);
        end
    endtask

    // drive one cycle, then wait for the next drive slot
    task automatic step(input logic v, input logic act, input logic [NEURONS-1:0] w,
                        input logic rd);
        in_v   = v;
        in_act = act;
        in_w   = w;
        rd_req = rd;
        if (v) begin
            record_beat(act, w, cyc + 1);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, 1'b0, '0, 1'b0);
    endtask

    task automatic read_once();
        step(1'b0, 1'b0, '0, 1'b1);
    endtask

    // rd_rate is reads per 16 cycles
    task automatic send_frame(input int mode, input int max_gap, input int rd_rate);
        logic [31:0]        rnd;
        logic               act;
        logic [NEURONS-1:0] w;
        int                 gap;
        for (int b = 0; b < VEC_LEN; b++) begin
            rnd = rand_next();
            act = rnd[16];
            case (mode)
                MODE_ONES:  w = {NEURONS{act}};
                MODE_ZEROS: w = ~{NEURONS{act}};
                MODE_HALF:  w = (b < VEC_LEN / 2) ? {NEURONS{act}} : ~{NEURONS{act}};
                default:    w = NEURONS'(rand_next());
            endcase
            rnd = rand_next();
            step(1'b1, act, w, rnd[31:28] < rd_rate);
            rnd = rand_next();
            gap = (max_gap > 0) ? int'(rnd[23:16]) % (max_gap + 1) : 0;
            repeat (gap) begin
                rnd = rand_next();
                step(1'b0, act, w, rnd[31:28] < rd_rate);
            end
        end
    endtask

    //////////////////////////////
    // stream checker
    //////////////////////////////

    // valid follows the strobe and data follows the model
    initial begin : stream_checker
        logic                rd_seen;
        logic [STREAM_W-1:0] exp_word;
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            rd_seen  = rd_req;
            exp_word = expected_word(cyc);
            @(negedge clk);
            check_value("stream.valid", rd_seen, stream.valid);
            if (rd_seen) begin
                check_value("stream.data", exp_word, stream.data);
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        arst_n    = 1'b0;
        in_v      = 1'b0;
        in_act    = 1'b0;
        in_w      = '0;
        rd_req    = 1'b0;
        err_cnt   = 0;
        check_cnt = 0;
        test_name = "reset";
        lcg_state = 32'h8ba8_7cf4;
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // nothing latched yet so expect zero
        idle_cycles(2);
        read_once();
        idle_cycles(2);

        // read two edges after the last beat
        test_name = "single_frame";
        send_frame(MODE_RAND, 0, 0);
        idle_cycles(1);
        read_once();
        idle_cycles(3);

        // no gaps so banks alternate every frame
        test_name = "back_to_back";
        repeat (N_B2B_FRAMES) send_frame(MODE_RAND, 0, 2);
        idle_cycles(1);
        read_once();
        idle_cycles(3);

        // all ones, all zeros, exact tie
        test_name = "ties_extremes";
        for (int m = MODE_ONES; m <= MODE_HALF; m++) begin
            send_frame(m, 0, 0);
            idle_cycles(1);
            read_once();
            idle_cycles(2);
        end

        // first read lands on the latch edge
        test_name = "read_at_latch";
        send_frame(MODE_RAND, 0, 0);
        read_once();
        read_once();
        idle_cycles(2);

        test_name = "random_gaps";
        repeat (N_GAP_FRAMES) send_frame(MODE_RAND, MAX_GAP, 3);
        idle_cycles(1);
        read_once();
        read_once();
        idle_cycles(3);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tb
src/bnn_pkg.sv
src/xnor_core.sv
src/seq_ctrl.sv
src/sign_counter.sv
src/dst_buf.sv
src/bnn_out_top.sv
tb/tb_bnn_out.sv

// ==== Bender.yml ====
package:
  name: bnn_out

sources:
  - files:
      - src/bnn_pkg.sv
      - src/xnor_core.sv
      - src/seq_ctrl.sv
      - src/sign_counter.sv
      - src/dst_buf.sv
      - src/bnn_out_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_bnn_out.sv
